/* hw/scrub_pkg.sv */
// scrub package: widths, register map, identity words, scrub limits and enums
`default_nettype none

package scrub_pkg;

  ////////////////////////////////////////
  // bus and data widths
  ////////////////////////////////////////

  localparam int APB_ADDR_W  = 8;
  localparam int APB_DATA_W  = 32;
  localparam int SCRB_ADDR_W = 32;
  localparam int ID_W        = 16;

  ////////////////////////////////////////
  // scrub region
  ////////////////////////////////////////

  // words covered by one burst request
  localparam logic [SCRB_ADDR_W-1:0] SCRB_BURST_BEATS = 32'd16;
  // kept small so a full walk is 16 requests
  localparam logic [SCRB_ADDR_W-1:0] SCRB_MAX_ADDR    = 32'd255;
  localparam logic [SCRB_ADDR_W-1:0] SCRB_LAST_START  =
    SCRB_MAX_ADDR + 32'd1 - SCRB_BURST_BEATS;

  // identity words when debug is off
  localparam logic [ID_W-1:0] CL_ID0 = 16'h5c01;
  localparam logic [ID_W-1:0] CL_ID1 = 16'h0a17;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  typedef enum logic [APB_ADDR_W-1:0] {
    CSR_CTL    = 8'h00,
    CSR_STATUS = 8'h04,
    CSR_ADDR_A = 8'h08,
    CSR_ADDR_B = 8'h0C
  } csr_addr_e;

  // ctl word fields
  localparam int CTL_EN_A    = 0;
  localparam int CTL_EN_B    = 1;
  // 0 shows channel a, 1 shows channel b
  localparam int CTL_DBG_SEL = 28;
  localparam int CTL_DBG_EN  = 31;

  // walker fsm
  typedef enum logic [1:0] {
    WALK_IDLE = 2'd0,
    WALK_BUSY = 2'd1,
    WALK_DONE = 2'd2
  } walk_state_e;

endpackage

`default_nettype wire

/* hw/scrub_walker.sv */
// scrub walker: steps burst-start addresses over the scrub region and flags completion
`timescale 1ns/1ps
`default_nettype none

module scrub_walker (
  input  wire                                 clk_main_a0,
  input  wire                                 rst_main_n,

  input  wire                                 i_enable,

  // burst request port
  output logic                                o_req_valid,
  output logic [scrub_pkg::SCRB_ADDR_W-1:0]   o_req_addr,
  input  wire                                 i_req_ready,

  output logic                                o_busy,
  output logic                                o_done
);

  import scrub_pkg::*;

  walk_state_e            state_q;
  logic [SCRB_ADDR_W-1:0] addr_q;
  logic                   req_fire;
  logic                   last_req;

  assign req_fire = o_req_valid && i_req_ready;
  assign last_req = (addr_q == SCRB_LAST_START);

  ////////////////////////////////////////
  // walk fsm
  ////////////////////////////////////////

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      state_q <= WALK_IDLE;
      addr_q  <= '0;
    end else begin
      case (state_q)
        // address is already zero here
        WALK_IDLE: begin
          if (i_enable) begin
            state_q <= WALK_BUSY;
          end
        end
        WALK_BUSY: begin
          if (!i_enable) begin
            state_q <= WALK_IDLE;
            addr_q  <= '0;
          end else if (req_fire) begin
            if (last_req) begin
              state_q <= WALK_DONE;
            end else begin
              addr_q <= addr_q + SCRB_BURST_BEATS;
            end
          end
        end
        // hold last start address until the enable drops
        WALK_DONE: begin
          if (!i_enable) begin
            state_q <= WALK_IDLE;
            addr_q  <= '0;
          end
        end
        default: begin
          state_q <= WALK_IDLE;
          addr_q  <= '0;
        end
      endcase
    end
  end

  assign o_req_valid = (state_q == WALK_BUSY);
  assign o_req_addr  = addr_q;
  assign o_busy      = (state_q == WALK_BUSY);
  assign o_done      = (state_q == WALK_DONE);

  // request stays put under back-pressure unless the channel is switched off
  a_req_hold: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    (o_req_valid && !i_req_ready && i_enable) |=> (o_req_valid && $stable(o_req_addr))
  );

  a_addr_limit: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    o_req_addr <= SCRB_LAST_START
  );

endmodule

`default_nettype wire

/* hw/scrub_csr.sv */
// scrub csr: apb register block with control word, status, id words and flr response
`timescale 1ns/1ps
`default_nettype none

module scrub_csr (
  input  wire                                 clk_main_a0,
  input  wire                                 rst_main_n,

  input  wire                                 i_psel,
  input  wire                                 i_penable,
  input  wire                                 i_pwrite,
  input  wire  [scrub_pkg::APB_ADDR_W-1:0]    i_paddr,
  input  wire  [scrub_pkg::APB_DATA_W-1:0]    i_pwdata,
  output logic                                o_pready,
  output logic [scrub_pkg::APB_DATA_W-1:0]    o_prdata,
  output logic                                o_pslverr,

  input  wire                                 i_flr_assert,
  output logic                                o_flr_done,

  output logic [scrub_pkg::ID_W-1:0]          o_id0,
  output logic [scrub_pkg::ID_W-1:0]          o_id1,

  output logic                                o_en_a,
  output logic                                o_en_b,
  input  wire  [scrub_pkg::SCRB_ADDR_W-1:0]   i_addr_a,
  input  wire  [scrub_pkg::SCRB_ADDR_W-1:0]   i_addr_b,
  input  wire                                 i_done_a,
  input  wire                                 i_done_b,
  input  wire                                 i_busy_a,
  input  wire                                 i_busy_b
);

  import scrub_pkg::*;

  logic                   apb_setup;
  logic                   apb_access;
  logic                   addr_hit;
  logic                   acc_err;
  logic                   ctl_wr;
  logic [APB_DATA_W-1:0]  rd_data;
  logic [APB_DATA_W-1:0]  status;
  logic [APB_DATA_W-1:0]  ctl_q;
  logic [SCRB_ADDR_W-1:0] dbg_addr;
  logic                   flr_assert_q;

  ////////////////////////////////////////
  // apb decode
  ////////////////////////////////////////

  assign apb_setup  = i_psel && !i_penable;
  assign apb_access = i_psel && i_penable;

  // done in the low byte, busy in the next one
  always_comb begin
    status    = '0;
    status[0] = i_done_a;
    status[1] = i_done_b;
    status[8] = i_busy_a;
    status[9] = i_busy_b;
  end

  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (i_paddr)
      CSR_CTL:    rd_data = ctl_q;
      CSR_STATUS: rd_data = status;
      CSR_ADDR_A: rd_data = i_addr_a;
      CSR_ADDR_B: rd_data = i_addr_b;
      default:    addr_hit = 1'b0;
    endcase
  end

  // only ctl is writable
  assign acc_err = !addr_hit || (i_pwrite && (i_paddr != CSR_CTL));
  assign ctl_wr  = apb_access && i_pwrite && !acc_err;

  // response is set up during the setup phase so access has no wait states
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      o_pready  <= 1'b0;
      o_pslverr <= 1'b0;
    end else begin
      o_pready  <= apb_setup;
      o_pslverr <= apb_setup && acc_err;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (apb_setup && !acc_err && !i_pwrite) begin
      o_prdata <= rd_data;
    end else begin
      o_prdata <= '0;
    end
  end

  ////////////////////////////////////////
  // control word
  ////////////////////////////////////////

  // flr wins over a write in the same cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      ctl_q <= '0;
    end else if (flr_assert_q) begin
      ctl_q <= '0;
    end else if (ctl_wr) begin
      ctl_q <= i_pwdata;
    end
  end

  assign o_en_a = ctl_q[CTL_EN_A];
  assign o_en_b = ctl_q[CTL_EN_B];

  ////////////////////////////////////////
  // id words
  ////////////////////////////////////////

  assign dbg_addr = ctl_q[CTL_DBG_SEL] ? i_addr_b : i_addr_a;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      o_id0 <= CL_ID0;
      o_id1 <= CL_ID1;
    end else if (ctl_q[CTL_DBG_EN]) begin
      o_id0 <= dbg_addr[ID_W-1:0];
      o_id1 <= dbg_addr[SCRB_ADDR_W-1:ID_W];
    end else begin
      o_id0 <= CL_ID0;
      o_id1 <= CL_ID1;
    end
  end

  ////////////////////////////////////////
  // flr auto response
  ////////////////////////////////////////

  // toggles while the request is held
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      flr_assert_q <= 1'b0;
      o_flr_done   <= 1'b0;
    end else begin
      flr_assert_q <= i_flr_assert;
      o_flr_done   <= flr_assert_q && !o_flr_done;
    end
  end

  // master side protocol
  a_penable_with_psel: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    i_penable |-> i_psel
  );

  // registered pready must line up with every access phase
  a_pready_in_access: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    apb_access |-> o_pready
  );

endmodule

`default_nettype wire

/* hw/scrub_top.sv */
// scrub top: apb register block driving two independent memory scrub walkers
`timescale 1ns/1ps
`default_nettype none

module scrub_top (
  input  wire                                 clk_main_a0,
  input  wire                                 rst_main_n,

  // apb slave
  input  wire                                 i_psel,
  input  wire                                 i_penable,
  input  wire                                 i_pwrite,
  input  wire  [scrub_pkg::APB_ADDR_W-1:0]    i_paddr,
  input  wire  [scrub_pkg::APB_DATA_W-1:0]    i_pwdata,
  output logic                                o_pready,
  output logic [scrub_pkg::APB_DATA_W-1:0]    o_prdata,
  output logic                                o_pslverr,

  // function level reset
  input  wire                                 i_flr_assert,
  output logic                                o_flr_done,

  // id words
  output logic [scrub_pkg::ID_W-1:0]          o_id0,
  output logic [scrub_pkg::ID_W-1:0]          o_id1,

  // channel a requests
  output logic                                o_req_a_valid,
  output logic [scrub_pkg::SCRB_ADDR_W-1:0]   o_req_a_addr,
  input  wire                                 i_req_a_ready,

  // channel b requests
  output logic                                o_req_b_valid,
  output logic [scrub_pkg::SCRB_ADDR_W-1:0]   o_req_b_addr,
  input  wire                                 i_req_b_ready
);

  logic en_a;
  logic en_b;
  logic done_a;
  logic done_b;
  logic busy_a;
  logic busy_b;

  scrub_csr csr_i (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_pslverr    (o_pslverr),
    .i_flr_assert (i_flr_assert),
    .o_flr_done   (o_flr_done),
    .o_id0        (o_id0),
    .o_id1        (o_id1),
    .o_en_a       (en_a),
    .o_en_b       (en_b),
    .i_addr_a     (o_req_a_addr),
    .i_addr_b     (o_req_b_addr),
    .i_done_a     (done_a),
    .i_done_b     (done_b),
    .i_busy_a     (busy_a),
    .i_busy_b     (busy_b)
  );

  // channel a
  scrub_walker walker_a_i (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .i_enable    (en_a),
    .o_req_valid (o_req_a_valid),
    .o_req_addr  (o_req_a_addr),
    .i_req_ready (i_req_a_ready),
    .o_busy      (busy_a),
    .o_done      (done_a)
  );

  // channel b
  scrub_walker walker_b_i (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .i_enable    (en_b),
    .o_req_valid (o_req_b_valid),
    .o_req_addr  (o_req_b_addr),
    .i_req_ready (i_req_b_ready),
    .o_busy      (busy_b),
    .o_done      (done_b)
  );

endmodule

`default_nettype wire

/* sim/tb_scrub_top.sv */
// scrub top testbench: replays the scrub test file through apb and the request ports
`timescale 1ns/1ps
`default_nettype none

module tb_scrub_top;

  import scrub_pkg::*;

  localparam int APB_TIMEOUT  = 16;
  localparam int WALK_TIMEOUT = 4000;
  localparam int FLR_TIMEOUT  = 16;

  typedef logic [8*24-1:0] name_t;

  logic                   clk_main_a0;
  logic                   rst_main_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [APB_ADDR_W-1:0]  paddr;
  logic [APB_DATA_W-1:0]  pwdata;
  logic                   pready;
  logic [APB_DATA_W-1:0]  prdata;
  logic                   pslverr;
  logic                   flr_assert;
  logic                   flr_done;
  logic [ID_W-1:0]        id0;
  logic [ID_W-1:0]        id1;
  logic                   req_a_valid;
  logic [SCRB_ADDR_W-1:0] req_a_addr;
  logic                   req_a_ready;
  logic                   req_b_valid;
  logic [SCRB_ADDR_W-1:0] req_b_addr;
  logic                   req_b_ready;
  logic [31:0]            lfsr_q;

  scrub_top dut_i (
    .clk_main_a0   (clk_main_a0),
    .rst_main_n    (rst_main_n),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .o_pready      (pready),
    .o_prdata      (prdata),
    .o_pslverr     (pslverr),
    .i_flr_assert  (flr_assert),
    .o_flr_done    (flr_done),
    .o_id0         (id0),
    .o_id1         (id1),
    .o_req_a_valid (req_a_valid),
    .o_req_a_addr  (req_a_addr),
    .i_req_a_ready (req_a_ready),
    .o_req_b_valid (req_b_valid),
    .o_req_b_addr  (req_b_addr),
    .i_req_b_ready (req_b_ready)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #10 clk_main_a0 = ~clk_main_a0;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b = lfsr_q[0];
  endtask

  // first non blank character of a right aligned text buffer
  function automatic logic [7:0] first_char(input logic [8*128-1:0] text);
    logic [7:0] c;
    c = 8'h00;
    for (int i = 127; i >= 0; i--) begin
      if (c == 8'h00 && text[i*8 +: 8] != 8'h00 && text[i*8 +: 8] != " ") begin
        c = text[i*8 +: 8];
      end
    end
    return c;
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input name_t name, input logic [APB_DATA_W-1:0] exp_val,
                            input logic [APB_DATA_W-1:0] act);
    if (act !== exp_val) begin
      $display("FAILED %0s: expected %h, actual %h", name, exp_val, act);
      abort_run();
    end
  endtask

  task automatic check_id(input name_t name, input logic [ID_W-1:0] exp_val,
                          input logic [ID_W-1:0] act);
    if (act !== exp_val) begin
      $display("FAILED %0s: expected %h, actual %h", name, exp_val, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input name_t name, input logic [SCRB_ADDR_W-1:0] exp_val,
                            input logic [SCRB_ADDR_W-1:0] act);
    if (act !== exp_val) begin
      $display("FAILED %0s: expected %h, actual %h", name, exp_val, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input name_t name, input logic exp_val, input logic act);
    if (act !== exp_val) begin
      $display("FAILED %0s: expected %b, actual %b", name, exp_val, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // apb master
  ////////////////////////////////////////

  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] wdata,
                          output logic [APB_DATA_W-1:0] rdata, output logic err);
    int waited;
    @(posedge clk_main_a0);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_main_a0);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk_main_a0);
    while (!pready) begin
      waited++;
      if (waited > APB_TIMEOUT) begin
        $display("timeout: apb slave never raised pready");
        abort_run();
      end
      @(negedge clk_main_a0);
    end
    rdata = prdata;
    err   = pslverr;
    // a write lands on this edge
    @(posedge clk_main_a0);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                           input logic [APB_DATA_W-1:0] wdata, output logic err);
    logic [APB_DATA_W-1:0] unused_rdata;
    apb_xfer(1'b1, addr, wdata, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                          output logic [APB_DATA_W-1:0] rdata, output logic err);
    apb_xfer(1'b0, addr, '0, rdata, err);
  endtask

  ////////////////////////////////////////
  // walk and flr steps
  ////////////////////////////////////////

  // random ready on both channels until every channel in the mask is done
  task automatic run_walk(input name_t name, input logic [1:0] mask,
                          input logic [APB_DATA_W-1:0] exp_cnt);
    logic [APB_DATA_W-1:0] cnt_a;
    logic [APB_DATA_W-1:0] cnt_b;
    logic                  rdy;
    int                    cycles;
    cnt_a  = '0;
    cnt_b  = '0;
    cycles = 0;
    @(negedge clk_main_a0);
    while ((mask[0] && !dut_i.done_a) || (mask[1] && !dut_i.done_b)) begin
      cycles++;
      if (cycles > WALK_TIMEOUT) begin
        $display("timeout: scrub walk never reached done");
        abort_run();
      end
      @(posedge clk_main_a0);
      take_bit(rdy);
      req_a_ready <= rdy;
      take_bit(rdy);
      req_b_ready <= rdy;
      @(negedge clk_main_a0);
      if (req_a_valid && req_a_ready) begin
        check_addr(name, cnt_a * SCRB_BURST_BEATS, req_a_addr);
        cnt_a = cnt_a + 1;
      end
      if (req_b_valid && req_b_ready) begin
        check_addr(name, cnt_b * SCRB_BURST_BEATS, req_b_addr);
        cnt_b = cnt_b + 1;
      end
    end
    @(posedge clk_main_a0);
    req_a_ready <= 1'b0;
    req_b_ready <= 1'b0;
    check_data(name, mask[0] ? exp_cnt : '0, cnt_a);
    check_data(name, mask[1] ? exp_cnt : '0, cnt_b);
  endtask

  // memory accepts every request so the walk is moving when the flr lands
  task automatic flr_pulse(input name_t name, input logic [APB_DATA_W-1:0] exp_len);
    logic [APB_DATA_W-1:0] len;
    int                    waited;
    @(posedge clk_main_a0);
    req_a_ready <= 1'b1;
    req_b_ready <= 1'b1;
    flr_assert  <= 1'b1;
    @(posedge clk_main_a0);
    flr_assert <= 1'b0;
    waited = 0;
    @(negedge clk_main_a0);
    while (!flr_done) begin
      waited++;
      if (waited > FLR_TIMEOUT) begin
        $display("timeout: flr request never answered by flr done");
        abort_run();
      end
      @(negedge clk_main_a0);
    end
    len = '0;
    while (flr_done) begin
      len = len + 1;
      if (len > FLR_TIMEOUT) begin
        $display("timeout: flr done stayed high after the request ended");
        abort_run();
      end
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    req_a_ready <= 1'b0;
    req_b_ready <= 1'b0;
    check_data(name, exp_len, len);
  endtask

  task automatic run_step(input name_t name, input logic [8*8-1:0] op,
                          input logic [APB_ADDR_W-1:0] off,
                          input logic [APB_DATA_W-1:0] data,
                          input logic [APB_DATA_W-1:0] exp_val);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    case (op)
      64'("write"): begin
        apb_write(off, data, err);
        check_flag(name, exp_val[0], err);
      end
      64'("read"): begin
        apb_read(off, rdata, err);
        check_flag(name, data[0], err);
        check_data(name, exp_val, rdata);
      end
      64'("run"): begin
        run_walk(name, data[1:0], exp_val);
      end
      64'("id"): begin
        // id words trail ctl by one cycle
        @(negedge clk_main_a0);
        @(negedge clk_main_a0);
        check_id(name, exp_val[ID_W-1:0], id0);
        check_id(name, exp_val[APB_DATA_W-1:ID_W], id1);
      end
      64'("dbgid"): begin
        apb_read(off, rdata, err);
        check_flag(name, 1'b0, err);
        check_addr(name, exp_val, rdata);
        check_id(name, rdata[ID_W-1:0], id0);
        check_id(name, rdata[SCRB_ADDR_W-1:ID_W], id1);
      end
      64'("flr"): begin
        flr_pulse(name, exp_val);
      end
      default: begin
        $display("unknown operation in test step %0s", name);
        abort_run();
      end
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int                    fd;
    int                    rc;
    int                    n_steps;
    logic [8*128-1:0]      line;
    name_t                 name;
    logic [8*8-1:0]        op;
    logic [APB_ADDR_W-1:0] off;
    logic [APB_DATA_W-1:0] data;
    logic [APB_DATA_W-1:0] exp_val;
    lfsr_q = 32'h7847bf1a;
    rst_main_n  <= 1'b0;
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    paddr       <= '0;
    pwdata      <= '0;
    flr_assert  <= 1'b0;
    req_a_ready <= 1'b0;
    req_b_ready <= 1'b0;
    repeat (8) @(posedge clk_main_a0);
    rst_main_n <= 1'b1;
    fd = $fopen("sim/scrub_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file sim/scrub_tests.txt");
      abort_run();
    end
    n_steps = 0;
    while (!$feof(fd)) begin
      line = '0;
      rc = $fgets(line, fd);
      if (rc > 0 && first_char(line) != "#") begin
        rc = $sscanf(line, "%s %s %h %h %h", name, op, off, data, exp_val);
        if (rc == 5) begin
          run_step(name, op, off, data, exp_val);
          n_steps++;
        end else if (rc > 0) begin
          $display("malformed line in the test file: %0s", line);
          abort_run();
        end
      end
    end
    $fclose(fd);
    if (n_steps == 0) begin
      $display("no test steps were found in the test file");
      abort_run();
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hw/scrub_pkg.sv
hw/scrub_walker.sv
hw/scrub_csr.sv
hw/scrub_top.sv
sim/tb_scrub_top.sv

/* Makefile */
# verilator lint and simulation for the scrub project
TOOL       := verilator
TOP        := tb_scrub_top
RTL_TOP    := scrub_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

# the log is searched for the pass line, so a fatal stop fails the target
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/scrub_tests.txt */
# columns: name op offset(hex) data(hex) expected(hex)
# write: expected is pslverr; read: data is pslverr, expected is read data
# run: data is channel mask, expected is requests per enabled channel
# id: expected is {o_id1, o_id0}; dbgid: reads offset, expected is the address
# flr: expected is the done pulse length in cycles
rst_ctl        read   00 0        00000000
rst_status     read   04 0        00000000
rst_id         id     00 0        0a175c01
ctl_wr         write  00 12345670 0
ctl_rdback     read   00 0        12345670
bad_off_rd     read   10 1        00000000
bad_off_wr     write  20 deadbeef 1
status_wr      write  04 ffffffff 1
addr_a_wr      write  08 0000aaaa 1
ctl_keep       read   00 0        12345670
status_keep    read   04 0        00000000
ctl_clr        write  00 00000000 0
a_en           write  00 00000001 0
a_walk         run    00 1        00000010
a_status       read   04 0        00000001
a_addr         read   08 0        000000f0
b_addr_idle    read   0c 0        00000000
dbg_a_on       write  00 80000001 0
dbg_a_id       dbgid  08 0        000000f0
dbg_b_on       write  00 90000001 0
dbg_b_id       dbgid  0c 0        00000000
dbg_off        write  00 00000001 0
dbg_off_id     id     00 0        0a175c01
ab_clr_first   write  00 00000000 0
ab_en          write  00 00000003 0
ab_walk        run    00 3        00000010
ab_status      read   04 0        00000003
ab_addr_a      read   08 0        000000f0
ab_addr_b      read   0c 0        000000f0
ab_clr         write  00 00000000 0
ab_clr_status  read   04 0        00000000
ab_clr_addr_a  read   08 0        00000000
ab_clr_addr_b  read   0c 0        00000000
flr_en         write  00 00000001 0
flr_busy       read   04 0        00000100
flr_pulse      flr    00 0        00000001
flr_ctl        read   00 0        00000000
flr_status     read   04 0        00000000
flr_addr       read   08 0        00000000
